// File: Makefile
# Verilator build and run for the multimeter core
# all variables can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_dmm_top
FLIST     ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(SIM_BIN): $(FLIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "test passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: adc_mock.sv
// aperture timer in place of the adc
`timescale 1ns/100ps

module adc_mock (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic [dmm_reg_pkg::REG_W-1:0]       aperture_i,
  input  logic                                adc_start_i,
  output logic                                adc_valid_o,
  output logic [dmm_io_pkg::ADC_MON_W-1:0]    monitor_o
);
  import dmm_reg_pkg::*;
  import dmm_io_pkg::*;

  logic [REG_W-1:0] cnt_q;   // aperture clks so far

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q       <= '0;
      adc_valid_o <= 1'b0;
    end else if (!adc_start_i) begin
      cnt_q       <= '0;     // start low acts as adc reset
      adc_valid_o <= 1'b0;
    end else if (!adc_valid_o) begin
      cnt_q <= cnt_q + 1'b1;
      // valid lands exactly aperture clks after start
      if (cnt_q + 1'b1 >= aperture_i) begin
        adc_valid_o <= 1'b1;
      end
    end
  end

  assign monitor_o = cnt_q[ADC_MON_W-1:0];   // count activity for the scope

endmodule

// File: az_sequencer.sv
// auto-zero sample acquisition
`timescale 1ns/100ps

module az_sequencer (
  input  logic                    clk,
  input  logic                    rst_n_i,
  input  dmm_reg_pkg::reg_file_t  regs_i,
  input  logic                    adc_valid_i,
  output logic                    adc_start_o,
  output dmm_io_pkg::seq_out_t    seq_o
);
  import dmm_reg_pkg::*;
  import dmm_io_pkg::*;

  az_state_t              state_q;
  logic [PRECHARGE_W-1:0] cnt_q;    // precharge cycles left
  logic                   side_q;   // 1 = hi input
  logic                   done_q;

  ////////////////////////////////////////
  // state machine

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      side_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (regs_i.arm) begin
            side_q  <= 1'b1;              // first sample is hi
            cnt_q   <= regs_i.precharge;
            state_q <= PRECHARGE;
          end
        end
        PRECHARGE: begin
          // zero or one both give a single cycle
          if (cnt_q <= 1) begin
            state_q <= SAMPLE;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        SAMPLE: begin
          if (adc_valid_i) begin
            state_q <= RELEASE;           // start drops here
          end
        end
        RELEASE: begin
          // wait for the adc to close out the handshake
          if (!adc_valid_i) begin
            done_q  <= 1'b1;
            side_q  <= ~side_q;
            cnt_q   <= regs_i.precharge;
            state_q <= regs_i.arm ? PRECHARGE : IDLE;   // disarm finishes the sample
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign adc_start_o = (state_q == SAMPLE);

  ////////////////////////////////////////
  // switch outputs

  always_comb begin
    seq_o               = '0;
    seq_o.state         = state_q;
    seq_o.side          = side_q;
    seq_o.meas_complete = done_q;
    seq_o.azmux         = side_q ? regs_i.azmux_hi : regs_i.azmux_lo;
    if (state_q == IDLE) begin
      seq_o.azmux = regs_i.azmux_lo;   // park on lo
    end
    if (state_q == SAMPLE) begin
      seq_o.pc_sw = regs_i.pc_sw_hi;   // precharge sw released for sampling
    end
  end

endmodule

// File: compile.f
dmm_reg_pkg.sv
dmm_io_pkg.sv
spi_slave.sv
register_bank.sv
az_sequencer.sv
adc_mock.sv
pin_mux.sv
dmm_top.sv
tb_dmm_top.sv

// File: dmm_io_pkg.sv
// pin vector and sequencer definitions
package dmm_io_pkg;

  ////////////////////////////////////////
  // field widths

  localparam int PINS_W    = 25;
  localparam int AZMUX_W   = 4;
  localparam int PC_SW_W   = 2;
  localparam int MONITOR_W = 8;
  localparam int LEDS_W    = 4;
  localparam int REFMUX_W  = 4;
  localparam int ADC_MON_W = 6;   // mock adc count bits on the monitor
  localparam int STATE_W   = 3;
  localparam int MODE_W    = 3;
  localparam int ROUTE_W   = 2;

  // pin vector, top bit down
  typedef struct packed {
    logic                 meas_complete;
    logic                 spi_interrupt;
    logic                 cmpr_latch;
    logic [REFMUX_W-1:0]  adc_refmux;
    logic [AZMUX_W-1:0]   azmux;
    logic [PC_SW_W-1:0]   pc_sw;
    logic [MONITOR_W-1:0] monitor;
    logic [LEDS_W-1:0]    leds;
  } pins_t;

  ////////////////////////////////////////
  // mode and route codes

  localparam logic [MODE_W-1:0] MODE_DIRECT  = 3'd0;
  localparam logic [MODE_W-1:0] MODE_LO      = 3'd1;
  localparam logic [MODE_W-1:0] MODE_HI      = 3'd2;
  localparam logic [MODE_W-1:0] MODE_PATTERN = 3'd3;
  localparam logic [MODE_W-1:0] MODE_AZ      = 3'd4;

  localparam logic [ROUTE_W-1:0] ROUTE_PARK = 2'd0;   // lines parked high
  localparam logic [ROUTE_W-1:0] ROUTE_4094 = 2'd1;
  localparam logic [ROUTE_W-1:0] ROUTE_DAC  = 2'd2;

  typedef enum logic [STATE_W-1:0] {
    IDLE,
    PRECHARGE,
    SAMPLE,
    RELEASE
  } az_state_t;

  typedef struct packed {
    logic [AZMUX_W-1:0] azmux;
    logic [PC_SW_W-1:0] pc_sw;
    az_state_t          state;
    logic               side;            // 1 hi, 0 lo
    logic               meas_complete;   // one clk pulse
  } seq_out_t;

endpackage

// File: dmm_reg_pkg.sv
// register map definitions
package dmm_reg_pkg;

  ////////////////////////////////////////
  // widths

  localparam int REG_W       = 32;
  localparam int ADDR_W      = 7;
  localparam int CMD_BITS    = 8;             // write flag + address
  localparam int FRAME_BITS  = CMD_BITS + REG_W;
  localparam int HW_FLAGS_W  = 4;
  localparam int PRECHARGE_W = 24;

  ////////////////////////////////////////
  // register addresses

  localparam logic [ADDR_W-1:0] ADDR_SPI_MUX   = 7'd0;
  localparam logic [ADDR_W-1:0] ADDR_4094_OE   = 7'd1;
  localparam logic [ADDR_W-1:0] ADDR_MODE      = 7'd2;
  localparam logic [ADDR_W-1:0] ADDR_DIRECT    = 7'd3;
  localparam logic [ADDR_W-1:0] ADDR_STATUS    = 7'd4;   // read only
  localparam logic [ADDR_W-1:0] ADDR_ARM       = 7'd5;
  localparam logic [ADDR_W-1:0] ADDR_PRECHARGE = 7'd6;
  localparam logic [ADDR_W-1:0] ADDR_AZMUX_LO  = 7'd7;
  localparam logic [ADDR_W-1:0] ADDR_AZMUX_HI  = 7'd8;
  localparam logic [ADDR_W-1:0] ADDR_PC_SW_HI  = 7'd9;
  localparam logic [ADDR_W-1:0] ADDR_APERTURE  = 7'd10;

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;   // lets the host spot a dead link

  // one decoded write from the spi side
  typedef struct packed {
    logic              wr;      // single cycle strobe
    logic [ADDR_W-1:0] addr;
    logic [REG_W-1:0]  data;
  } reg_wr_t;

  // writable registers, trimmed to the bits in use
  typedef struct packed {
    logic [1:0]             spi_mux;
    logic                   oe_4094;
    logic [2:0]             mode;
    logic [24:0]            direct;
    logic                   arm;
    logic [PRECHARGE_W-1:0] precharge;   // clk counts
    logic [3:0]             azmux_lo;
    logic [3:0]             azmux_hi;
    logic [1:0]             pc_sw_hi;
    logic [REG_W-1:0]       aperture;    // clk counts, long samples
  } reg_file_t;

endpackage

// File: dmm_top.sv
// multimeter control core
`timescale 1ns/100ps

module dmm_top (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic                                sck_i,
  input  logic                                ss_i,
  input  logic                                sdi_i,
  input  logic                                spi_cs2_i,
  input  logic [dmm_reg_pkg::HW_FLAGS_W-1:0]  hw_flags_i,
  output logic                                sdo_o,
  output logic [dmm_io_pkg::LEDS_W-1:0]       leds_o,
  output logic [dmm_io_pkg::MONITOR_W-1:0]    monitor_o,
  output logic [dmm_io_pkg::PC_SW_W-1:0]      pc_sw_o,
  output logic [dmm_io_pkg::AZMUX_W-1:0]      azmux_o,
  output logic [dmm_io_pkg::REFMUX_W-1:0]     adc_refmux_o,
  output logic                                adc_cmpr_latch_ctl_o,
  output logic                                spi_interrupt_ctl_o,
  output logic                                meas_complete_o,
  output logic                                glb_spi_clk_o,
  output logic                                glb_spi_mosi_o,
  output logic                                glb_4094_strobe_o,
  output logic                                glb_4094_oe_o,
  output logic                                spi_dac_ss_o
);
  import dmm_reg_pkg::*;
  import dmm_io_pkg::*;

  reg_wr_t              spi_wr;
  logic [ADDR_W-1:0]    spi_rd_addr;
  logic [REG_W-1:0]     rd_data;
  reg_file_t            regs;
  logic                 adc_start;
  logic                 adc_valid;
  logic [ADC_MON_W-1:0] adc_monitor;
  seq_out_t             seq;
  pins_t                pins;

  ////////////////////////////////////////
  // host side

  spi_slave spi_slave (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .sck_i     (sck_i),
    .ss_i      (ss_i),
    .sdi_i     (sdi_i),
    .rd_data_i (rd_data),
    .sdo_o     (sdo_o),
    .rd_addr_o (spi_rd_addr),
    .wr_o      (spi_wr)
  );

  register_bank register_bank (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wr_i       (spi_wr),
    .rd_addr_i  (spi_rd_addr),
    .hw_flags_i (hw_flags_i),
    .rd_data_o  (rd_data),
    .regs_o     (regs)
  );

  ////////////////////////////////////////
  // acquisition

  az_sequencer az_sequencer (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .regs_i      (regs),
    .adc_valid_i (adc_valid),
    .adc_start_o (adc_start),
    .seq_o       (seq)
  );

  adc_mock adc_mock (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .aperture_i  (regs.aperture),
    .adc_start_i (adc_start),
    .adc_valid_o (adc_valid),
    .monitor_o   (adc_monitor)
  );

  pin_mux pin_mux (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .regs_i            (regs),
    .seq_i             (seq),
    .adc_valid_i       (adc_valid),
    .adc_monitor_i     (adc_monitor),
    .sck_i             (sck_i),
    .sdi_i             (sdi_i),
    .cs2_i             (spi_cs2_i),
    .pins_o            (pins),
    .glb_spi_clk_o     (glb_spi_clk_o),
    .glb_spi_mosi_o    (glb_spi_mosi_o),
    .glb_4094_strobe_o (glb_4094_strobe_o),
    .glb_4094_oe_o     (glb_4094_oe_o),
    .spi_dac_ss_o      (spi_dac_ss_o)
  );

  // pin vector out to the board
  assign meas_complete_o      = pins.meas_complete;
  assign spi_interrupt_ctl_o  = pins.spi_interrupt;
  assign adc_cmpr_latch_ctl_o = pins.cmpr_latch;
  assign adc_refmux_o         = pins.adc_refmux;
  assign azmux_o              = pins.azmux;
  assign pc_sw_o              = pins.pc_sw;
  assign monitor_o            = pins.monitor;
  assign leds_o               = pins.leds;

endmodule

// File: pin_mux.sv
// pin source select and spi routing
`timescale 1ns/100ps

module pin_mux (
  input  logic                               clk,
  input  logic                               rst_n_i,
  input  dmm_reg_pkg::reg_file_t             regs_i,
  input  dmm_io_pkg::seq_out_t               seq_i,
  input  logic                               adc_valid_i,
  input  logic [dmm_io_pkg::ADC_MON_W-1:0]   adc_monitor_i,
  input  logic                               sck_i,
  input  logic                               sdi_i,
  input  logic                               cs2_i,
  output dmm_io_pkg::pins_t                  pins_o,
  output logic                               glb_spi_clk_o,
  output logic                               glb_spi_mosi_o,
  output logic                               glb_4094_strobe_o,
  output logic                               glb_4094_oe_o,
  output logic                               spi_dac_ss_o
);
  import dmm_io_pkg::*;

  logic [PINS_W-1:0] pattern_q;   // free running test count
  pins_t             az_pins;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pattern_q <= '0;
    end else begin
      pattern_q <= pattern_q + 1'b1;
    end
  end

  ////////////////////////////////////////
  // auto-zero pin vector

  always_comb begin
    az_pins               = '0;   // refmux and cmpr latch unused here
    az_pins.meas_complete = seq_i.meas_complete;
    az_pins.spi_interrupt = seq_i.meas_complete;
    az_pins.azmux         = seq_i.azmux;
    az_pins.pc_sw         = seq_i.pc_sw;
    az_pins.monitor       = {adc_valid_i, adc_monitor_i[3:0], seq_i.state};
    az_pins.leds[0]       = seq_i.side;
  end

  // mode select, straight from the register
  always_comb begin
    case (regs_i.mode)
      MODE_DIRECT:  pins_o = pins_t'(regs_i.direct);
      MODE_LO:      pins_o = '0;
      MODE_HI:      pins_o = '1;
      MODE_PATTERN: pins_o = pins_t'(pattern_q);
      MODE_AZ:      pins_o = az_pins;
      default:      pins_o = '0;   // spare modes held low
    endcase
  end

  ////////////////////////////////////////
  // spi routing

  assign glb_spi_clk_o     = (regs_i.spi_mux == ROUTE_PARK) ? 1'b1 : sck_i;  // park hi
  assign glb_spi_mosi_o    = (regs_i.spi_mux == ROUTE_PARK) ? 1'b1 : sdi_i;
  assign glb_4094_strobe_o = (regs_i.spi_mux == ROUTE_4094) ? ~cs2_i : 1'b0; // active hi
  assign spi_dac_ss_o      = (regs_i.spi_mux == ROUTE_DAC) ? cs2_i : 1'b1;   // active lo
  assign glb_4094_oe_o     = regs_i.oe_4094;                                 // off at power up

endmodule

// File: register_bank.sv
// writable registers and readback
`timescale 1ns/100ps

module register_bank (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  dmm_reg_pkg::reg_wr_t                wr_i,
  input  logic [dmm_reg_pkg::ADDR_W-1:0]      rd_addr_i,
  input  logic [dmm_reg_pkg::HW_FLAGS_W-1:0]  hw_flags_i,
  output logic [dmm_reg_pkg::REG_W-1:0]       rd_data_o,
  output dmm_reg_pkg::reg_file_t              regs_o
);
  import dmm_reg_pkg::*;

  logic [REG_W-1:0] status_w;

  // zeros, board flags, magic byte
  assign status_w = {{(REG_W - HW_FLAGS_W - $bits(STATUS_MAGIC)){1'b0}},
                     hw_flags_i, STATUS_MAGIC};

  ////////////////////////////////////////
  // writes

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      regs_o <= '0;   // direct mode, spi parked, 4094 off
    end else if (wr_i.wr) begin
      case (wr_i.addr)
        ADDR_SPI_MUX:   regs_o.spi_mux   <= wr_i.data[1:0];
        ADDR_4094_OE:   regs_o.oe_4094   <= wr_i.data[0];
        ADDR_MODE:      regs_o.mode      <= wr_i.data[2:0];
        ADDR_DIRECT:    regs_o.direct    <= wr_i.data[24:0];
        ADDR_ARM:       regs_o.arm       <= wr_i.data[0];
        ADDR_PRECHARGE: regs_o.precharge <= wr_i.data[PRECHARGE_W-1:0];
        ADDR_AZMUX_LO:  regs_o.azmux_lo  <= wr_i.data[3:0];
        ADDR_AZMUX_HI:  regs_o.azmux_hi  <= wr_i.data[3:0];
        ADDR_PC_SW_HI:  regs_o.pc_sw_hi  <= wr_i.data[1:0];
        ADDR_APERTURE:  regs_o.aperture  <= wr_i.data;
        default: ;      // status and holes drop the write
      endcase
    end
  end

  ////////////////////////////////////////
  // reads, zero extended

  always_comb begin
    case (rd_addr_i)
      ADDR_SPI_MUX:   rd_data_o = REG_W'(regs_o.spi_mux);
      ADDR_4094_OE:   rd_data_o = REG_W'(regs_o.oe_4094);
      ADDR_MODE:      rd_data_o = REG_W'(regs_o.mode);
      ADDR_DIRECT:    rd_data_o = REG_W'(regs_o.direct);
      ADDR_STATUS:    rd_data_o = status_w;
      ADDR_ARM:       rd_data_o = REG_W'(regs_o.arm);
      ADDR_PRECHARGE: rd_data_o = REG_W'(regs_o.precharge);
      ADDR_AZMUX_LO:  rd_data_o = REG_W'(regs_o.azmux_lo);
      ADDR_AZMUX_HI:  rd_data_o = REG_W'(regs_o.azmux_hi);
      ADDR_PC_SW_HI:  rd_data_o = REG_W'(regs_o.pc_sw_hi);
      ADDR_APERTURE:  rd_data_o = regs_o.aperture;
      default:        rd_data_o = '0;
    endcase
  end

endmodule

// File: spi_slave.sv
// oversampled spi command slave
`timescale 1ns/100ps

module spi_slave (
  input  logic                              clk,
  input  logic                              rst_n_i,
  input  logic                              sck_i,
  input  logic                              ss_i,
  input  logic                              sdi_i,
  input  logic [dmm_reg_pkg::REG_W-1:0]     rd_data_i,
  output logic                              sdo_o,
  output logic [dmm_reg_pkg::ADDR_W-1:0]    rd_addr_o,
  output dmm_reg_pkg::reg_wr_t              wr_o
);
  import dmm_reg_pkg::*;

  logic [2:0] sck_q;   // two sync flops + one for edge detect
  logic [2:0] ss_q;
  logic [1:0] sdi_q;
  logic       sck_rise;
  logic       sck_fall;
  logic       ss_rise;
  logic [$clog2(FRAME_BITS+1)-1:0] bit_cnt_q;   // rising edges this frame
  logic       wr_flag_q;
  logic       load_q;                           // read data valid next cycle
  logic [REG_W-1:0] shift_q;
  logic [REG_W-1:0] tx_q;

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign ss_rise  = ss_q[1] & ~ss_q[2];         // end of frame

  ////////////////////////////////////////
  // pin synchronizers

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sck_q <= 3'b000;
      ss_q  <= 3'b111;   // deselected
      sdi_q <= 2'b00;
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      ss_q  <= {ss_q[1:0], ss_i};
      sdi_q <= {sdi_q[0], sdi_i};
    end
  end

  ////////////////////////////////////////
  // frame decode

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bit_cnt_q <= '0;
      wr_flag_q <= 1'b0;
      rd_addr_o <= '0;
      load_q    <= 1'b0;
      wr_o      <= '0;
    end else begin
      wr_o.wr <= 1'b0;
      load_q  <= 1'b0;
      if (ss_q[1]) begin
        bit_cnt_q <= '0;
      end else if (sck_rise) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
        if (bit_cnt_q == CMD_BITS - 1) begin   // command byte completes
          wr_flag_q <= shift_q[CMD_BITS-2];
          rd_addr_o <= {shift_q[CMD_BITS-3:0], sdi_q[1]};
          load_q    <= 1'b1;
        end
      end
      // only a full write frame commits
      if (ss_rise && wr_flag_q && bit_cnt_q == FRAME_BITS) begin
        wr_o.wr   <= 1'b1;
        wr_o.addr <= rd_addr_o;
        wr_o.data <= shift_q;
      end
    end
  end

  // mosi shifter, msb first
  always_ff @(posedge clk) begin
    if (!ss_q[1] && sck_rise) begin
      shift_q <= {shift_q[REG_W-2:0], sdi_q[1]};
    end
  end

  // miso shifter, moves after each falling edge of the data phase
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_q <= '0;
    end else if (load_q) begin
      tx_q <= rd_data_i;
    end else if (sck_fall && bit_cnt_q > CMD_BITS) begin
      tx_q <= {tx_q[REG_W-2:0], 1'b0};
    end
  end

  assign sdo_o = tx_q[REG_W-1];

endmodule

// File: tb_dmm_top.sv
// multimeter core testbench
`timescale 1ns/100ps

module tb_dmm_top;
  import dmm_reg_pkg::*;
  import dmm_io_pkg::*;

  localparam int HALF_CLKS   = 4;      // sck half period in clk cycles
  localparam int SETTLE_CLKS = 8;      // ss rise until the register is updated
  localparam int AZ_TIMEOUT  = 2000;   // cycles for six samples
  localparam int DISARM_WAIT = 200;    // longer than one full sample

  logic        clk;
  logic        rst_n_i;
  logic        sck_i;
  logic        ss_i;
  logic        sdi_i;
  logic        spi_cs2_i;
  logic [3:0]  hw_flags_i;
  logic        sdo_o;
  logic [3:0]  leds_o;
  logic [7:0]  monitor_o;
  logic [1:0]  pc_sw_o;
  logic [3:0]  azmux_o;
  logic [3:0]  adc_refmux_o;
  logic        adc_cmpr_latch_ctl_o;
  logic        spi_interrupt_ctl_o;
  logic        meas_complete_o;
  logic        glb_spi_clk_o;
  logic        glb_spi_mosi_o;
  logic        glb_4094_strobe_o;
  logic        glb_4094_oe_o;
  logic        spi_dac_ss_o;
  logic [24:0] pins;                   // pin vector from the top bit down

  logic [31:0] model [0:10];           // register model holding used bits only
  integer      seed;
  int          total_errs;
  int          test_errs;
  int          tests_run;
  int          tests_failed;
  string       cur_test;

  assign pins = {meas_complete_o, spi_interrupt_ctl_o, adc_cmpr_latch_ctl_o,
                 adc_refmux_o, azmux_o, pc_sw_o, monitor_o, leds_o};

  dmm_top dut (
    .clk                  (clk),
    .rst_n_i              (rst_n_i),
    .sck_i                (sck_i),
    .ss_i                 (ss_i),
    .sdi_i                (sdi_i),
    .spi_cs2_i            (spi_cs2_i),
    .hw_flags_i           (hw_flags_i),
    .sdo_o                (sdo_o),
    .leds_o               (leds_o),
    .monitor_o            (monitor_o),
    .pc_sw_o              (pc_sw_o),
    .azmux_o              (azmux_o),
    .adc_refmux_o         (adc_refmux_o),
    .adc_cmpr_latch_ctl_o (adc_cmpr_latch_ctl_o),
    .spi_interrupt_ctl_o  (spi_interrupt_ctl_o),
    .meas_complete_o      (meas_complete_o),
    .glb_spi_clk_o        (glb_spi_clk_o),
    .glb_spi_mosi_o       (glb_spi_mosi_o),
    .glb_4094_strobe_o    (glb_4094_strobe_o),
    .glb_4094_oe_o        (glb_4094_oe_o),
    .spi_dac_ss_o         (spi_dac_ss_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  ////////////////////////////////////////
  // helpers

  // n clocks ending just after the edge where inputs change
  task automatic step(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
    end
  endtask

  // bits each register keeps
  function automatic logic [31:0] used_mask(input logic [6:0] addr);
    case (addr)
      ADDR_SPI_MUX, ADDR_PC_SW_HI:   used_mask = 32'h0000_0003;
      ADDR_4094_OE, ADDR_ARM:        used_mask = 32'h0000_0001;
      ADDR_MODE:                     used_mask = 32'h0000_0007;
      ADDR_DIRECT:                   used_mask = 32'h01ff_ffff;
      ADDR_PRECHARGE:                used_mask = 32'h00ff_ffff;
      ADDR_AZMUX_LO, ADDR_AZMUX_HI:  used_mask = 32'h0000_000f;
      ADDR_APERTURE:                 used_mask = 32'hffff_ffff;
      default:                       used_mask = 32'h0000_0000;
    endcase
  endfunction

  // one 40 bit mode 0 frame sent msb first
  task automatic spi_frame(input logic wr, input logic [6:0] addr,
                           input logic [31:0] data, output logic [31:0] rx);
    logic [39:0] frame;
    int          i;
    frame = {wr, addr, data};
    rx    = 32'h0;
    ss_i  = 1'b0;
    step(HALF_CLKS);
    for (i = 39; i >= 0; i--) begin
      sdi_i = frame[i];
      step(HALF_CLKS);
      if (i < 32) rx[i] = sdo_o;   // miso settled by end of low half
      sck_i = 1'b1;
      step(HALF_CLKS);
      sck_i = 1'b0;
    end
    step(HALF_CLKS);
    ss_i  = 1'b1;
    sdi_i = 1'b0;
    step(SETTLE_CLKS);             // write applied by now
  endtask

  task automatic spi_write(input logic [6:0] addr, input logic [31:0] data);
    logic [31:0] unused_rx;
    spi_frame(1'b1, addr, data, unused_rx);
    if (addr <= ADDR_APERTURE) model[addr] = data & used_mask(addr);
  endtask

  task automatic spi_read(input logic [6:0] addr, output logic [31:0] data);
    spi_frame(1'b0, addr, 32'h0, data);
  endtask

  task automatic report_mismatch(input logic [31:0] exp, input logic [31:0] act);
    $display("ERROR %s: expected %h, actual %h", cur_test, exp, act);
    test_errs++;
    total_errs++;
  endtask

  task automatic report_failure(input string what);
    $display("%s: %s", cur_test, what);
    test_errs++;
    total_errs++;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs == 0) begin
      $display("%s: ok", cur_test);
    end else begin
      $display("%s: %0d checks failed", cur_test, test_errs);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] rnd;
    logic [31:0] rd;
    logic [24:0] prev25;
    logic [24:0] exp25;
    logic [4:0]  route_exp;
    logic [4:0]  route_act;
    logic [3:0]  lo;
    logic [3:0]  hi;
    logic [3:0]  exp_az;
    logic [3:0]  az_seen;
    logic [1:0]  pcsw;
    logic        side;
    int          a;
    int          m;
    int          r;
    int          k;
    int          t;
    int          pulses;

    seed         = 32'hca2f;
    total_errs   = 0;
    test_errs    = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst_n_i      = 1'b0;
    sck_i        = 1'b0;
    ss_i         = 1'b1;
    sdi_i        = 1'b0;
    spi_cs2_i    = 1'b1;
    rnd          = $random(seed);
    hw_flags_i   = rnd[3:0];
    for (a = 0; a <= 10; a++) model[a] = 32'h0;
    step(3);
    rst_n_i = 1'b1;
    step(2);

    // every writable register then status and a hole
    begin_test("readback");
    for (a = 0; a <= 10; a++) begin
      if (a != ADDR_STATUS) begin
        rnd = $random(seed);
        if (a == ADDR_ARM) rnd[0] = 1'b0;   // sequencer stays idle
        spi_write(a[6:0], rnd);
      end
    end
    for (a = 0; a <= 10; a++) begin
      if (a != ADDR_STATUS) begin
        spi_read(a[6:0], rd);
        if (rd !== model[a]) report_mismatch(model[a], rd);
      end
    end
    spi_read(ADDR_STATUS, rd);
    if (rd !== {20'h0, hw_flags_i, 8'hAA}) report_mismatch({20'h0, hw_flags_i, 8'hAA}, rd);
    rnd = $random(seed);
    a   = 11 + int'(rnd % 32'd117);        // somewhere in 11..127
    spi_read(a[6:0], rd);
    if (rd !== 32'h0) report_mismatch(32'h0, rd);
    end_test();

    begin_test("static modes");
    rnd = $random(seed);
    spi_write(ADDR_DIRECT, rnd);
    for (m = 0; m < 8; m++) begin
      if (m != 3 && m != 4) begin
        spi_write(ADDR_MODE, 32'(m));
        if (m == 0) exp25 = model[ADDR_DIRECT][24:0];
        else if (m == 2) exp25 = '1;
        else exp25 = '0;                    // lo and spare modes
        if (pins !== exp25) report_mismatch({7'h0, exp25}, {7'h0, pins});
      end
    end
    end_test();

    begin_test("pattern");
    spi_write(ADDR_MODE, 32'd3);
    prev25 = pins;
    for (k = 0; k < 32; k++) begin
      step(1);
      exp25 = prev25 + 25'd1;               // wraps at 25 bits
      if (pins !== exp25) report_mismatch({7'h0, exp25}, {7'h0, pins});
      prev25 = pins;
    end
    end_test();

    // route 3 is unassigned and acts as a live route with no selects
    begin_test("spi routing");
    for (r = 0; r < 4; r++) begin
      rnd = $random(seed);
      spi_write(ADDR_4094_OE, rnd);
      spi_write(ADDR_SPI_MUX, 32'(r));
      for (k = 0; k < 16; k++) begin
        rnd       = $random(seed);
        sck_i     = rnd[0];
        sdi_i     = rnd[1];
        spi_cs2_i = rnd[2];
        step(1);
        route_exp[4] = (r == 0) ? 1'b1 : rnd[0];     // parked lines high
        route_exp[3] = (r == 0) ? 1'b1 : rnd[1];
        route_exp[2] = (r == 1) ? ~rnd[2] : 1'b0;    // 4094 strobe
        route_exp[1] = (r == 2) ? rnd[2] : 1'b1;     // dac select
        route_exp[0] = model[ADDR_4094_OE][0];
        route_act    = {glb_spi_clk_o, glb_spi_mosi_o, glb_4094_strobe_o,
                        spi_dac_ss_o, glb_4094_oe_o};
        if (route_act !== route_exp) report_mismatch({27'h0, route_exp}, {27'h0, route_act});
      end
      sck_i     = 1'b0;                     // idle sck before next frame
      sdi_i     = 1'b0;
      spi_cs2_i = 1'b1;
      step(HALF_CLKS);
    end
    end_test();

    begin_test("auto-zero");
    rnd  = $random(seed);
    lo   = rnd[3:0];
    hi   = lo ^ (4'd1 + rnd[7:4] % 4'd15);  // never equal to lo
    pcsw = rnd[9:8];
    spi_write(ADDR_AZMUX_LO, {28'h0, lo});
    spi_write(ADDR_AZMUX_HI, {28'h0, hi});
    spi_write(ADDR_PC_SW_HI, {30'h0, pcsw});
    rnd = $random(seed);
    spi_write(ADDR_PRECHARGE, 32'd4 + (rnd % 32'd8));
    rnd = $random(seed);
    spi_write(ADDR_APERTURE, 32'd3 + (rnd % 32'd10));
    spi_write(ADDR_MODE, 32'd4);
    spi_write(ADDR_ARM, 32'd1);
    pulses  = 0;
    side    = 1'b1;                         // first sample on hi
    az_seen = 4'h0;
    for (t = 0; t < AZ_TIMEOUT && pulses < 6; t++) begin
      step(1);
      if (dut.adc_start) begin              // sample phase
        az_seen = azmux_o;
        if (pc_sw_o !== pcsw) report_mismatch({30'h0, pcsw}, {30'h0, pc_sw_o});
      end
      if (meas_complete_o) begin
        exp_az = side ? hi : lo;
        if (az_seen !== exp_az) report_mismatch({28'h0, exp_az}, {28'h0, az_seen});
        if (spi_interrupt_ctl_o !== 1'b1) report_mismatch(32'h1, {31'h0, spi_interrupt_ctl_o});
        side = ~side;
        pulses++;
      end
      // side flips on the same edge as the pulse
      if (leds_o !== {3'b000, side}) report_mismatch({28'h0, 3'b000, side}, {28'h0, leds_o});
    end
    if (pulses < 6) report_failure("timed out waiting for six meas_complete pulses");
    spi_write(ADDR_ARM, 32'd0);
    pulses = 0;
    for (t = 0; t < DISARM_WAIT; t++) begin
      step(1);
      if (meas_complete_o) pulses++;
    end
    if (pulses > 1) report_failure("sequencer kept sampling after disarm");
    if (azmux_o !== lo) report_mismatch({28'h0, lo}, {28'h0, azmux_o});
    if (pc_sw_o !== 2'b00) report_mismatch(32'h0, {30'h0, pc_sw_o});
    end_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
